/* tlp_pkg.sv */
package tlp_pkg;

   // stream fields, width fixed by the hard ip
   typedef logic [127:0] data_t;     // one beat, four dwords
   typedef logic [15:0]  be_t;       // bit 0 = byte 0 of dword 0
   typedef logic [7:0]   bardec_t;   // one-hot bar hit
   typedef logic [10:0]  dw_count_t; // payload dwords, up to 1024
   typedef logic [31:0]  addr_t;     // tlp address and bar base

   // axi4-lite side
   typedef logic [3:0]   axil_addr_t;
   typedef logic [31:0]  axil_data_t;
   typedef logic [1:0]   axil_resp_t;

   // register write fsm
   typedef enum logic [0:0] {
      write_idle, // waiting for aw and w together
      write_resp  // bvalid held until bready
   } reg_wr_state_t;

   // header dword 0 layout
   localparam int FMT_PAYLOAD_BIT = 30; // fmt[1], tlp carries data
   localparam int FMT_4DW_BIT     = 29; // fmt[0], 4dw header
   localparam int LEN_MSB         = 9;  // length field is [9:0]

   // register map
   localparam axil_addr_t REG_BAR2_ADDR = 4'h0;
   localparam axil_addr_t REG_BAR3_ADDR = 4'h4;

   // base values out of reset
   localparam addr_t BAR2_BASE_RST = 32'h0020_0000;
   localparam addr_t BAR3_BASE_RST = 32'h0024_0000;

   // responses
   localparam axil_resp_t RESP_OKAY   = 2'b00;
   localparam axil_resp_t RESP_SLVERR = 2'b10;

   // one-hot bar codes
   localparam bardec_t BAR2_HIT = 8'b0000_0100;
   localparam bardec_t BAR3_HIT = 8'b0000_1000;

   // three registered stages, input beat to output beat
   localparam int PIPE_LATENCY = 3;

endpackage

/* tlp_hdr_parse.sv */
`timescale 1ns/1ps

module tlp_hdr_parse (
   input  logic              clk_in,
   input  logic              rstn,
   input  tlp_pkg::data_t    tx_st_data,
   input  logic              tx_st_sop,
   input  logic              tx_st_eop,
   input  logic              tx_st_valid,
   input  logic              tx_st_err,
   input  logic              tx_st_empty,
   output tlp_pkg::data_t    s1_data,
   output logic              s1_sop,
   output logic              s1_eop,
   output logic              s1_valid,
   output logic              s1_err,
   output logic              s1_empty,
   output logic              s1_hdr_3dw,     // held from last sop
   output logic              s1_has_payload,
   output tlp_pkg::dw_count_t s1_payload_dw, // length, 0 expanded
   output tlp_pkg::addr_t    s1_addr
);

   logic [tlp_pkg::LEN_MSB:0] len_field;
   logic                      is_4dw;
   logic                      has_data;
   tlp_pkg::dw_count_t        len_dw;
   tlp_pkg::addr_t            addr_sel;
   logic                      hdr_beat;

   // header decode straight off the input beat
   assign hdr_beat  = tx_st_valid & tx_st_sop;
   assign is_4dw    = tx_st_data[tlp_pkg::FMT_4DW_BIT];
   assign has_data  = tx_st_data[tlp_pkg::FMT_PAYLOAD_BIT];
   assign len_field = tx_st_data[tlp_pkg::LEN_MSB:0];

   // zero length field means 1024 dwords
   assign len_dw = (len_field == '0) ? tlp_pkg::dw_count_t'(1024)
                                     : tlp_pkg::dw_count_t'(len_field);

   // 3dw: address in dw2; 4dw: low address dw sits in dw3
   assign addr_sel = is_4dw ? tx_st_data[127:96] : tx_st_data[95:64];

   // control bits
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         s1_valid <= 1'b0;
         s1_sop   <= 1'b0;
         s1_eop   <= 1'b0;
      end else begin
         s1_valid <= tx_st_valid;
         s1_sop   <= tx_st_sop;
         s1_eop   <= tx_st_eop;
      end
   end

   // payload fields, every beat
   always_ff @(posedge clk_in) begin
      s1_data  <= tx_st_data;
      s1_err   <= tx_st_err;
      s1_empty <= tx_st_empty;
   end

   // header fields only move on a real header beat
   always_ff @(posedge clk_in) begin
      if (hdr_beat) begin
         s1_hdr_3dw     <= ~is_4dw;
         s1_has_payload <= has_data;
         s1_payload_dw  <= len_dw;
         s1_addr        <= addr_sel;
      end
   end

endmodule

/* tlp_be_gen.sv */
`timescale 1ns/1ps

module tlp_be_gen (
   input  logic               clk_in,
   input  logic               rstn,
   input  tlp_pkg::data_t     s1_data,
   input  logic               s1_sop,
   input  logic               s1_eop,
   input  logic               s1_valid,
   input  logic               s1_err,
   input  logic               s1_empty,
   input  logic               s1_hdr_3dw,
   input  logic               s1_has_payload,
   input  tlp_pkg::dw_count_t s1_payload_dw,
   input  tlp_pkg::addr_t     s1_addr,
   output tlp_pkg::data_t     s2_data,
   output logic               s2_sop,
   output logic               s2_eop,
   output logic               s2_valid,
   output logic               s2_err,
   output logic               s2_empty,
   output tlp_pkg::be_t       s2_be,
   output logic               s2_hdr_3dw,
   output tlp_pkg::addr_t     s2_addr
);

   tlp_pkg::dw_count_t rem_dw;     // payload dwords still to come
   tlp_pkg::dw_count_t rem_load;   // count loaded on sop
   tlp_pkg::be_t       sop_mask;
   tlp_pkg::be_t       tail_mask;
   tlp_pkg::be_t       be_next;

   // sop beat: header dwords, plus dw3 for 3dw with data
   assign sop_mask = (s1_hdr_3dw && !s1_has_payload) ? 16'h0fff : 16'hffff;

   // first payload dword rides in the 3dw header beat
   always_comb begin
      if (!s1_has_payload)
         rem_load = '0;
      else if (s1_hdr_3dw)
         rem_load = s1_payload_dw - 1'b1;
      else
         rem_load = s1_payload_dw;
   end

   // lowest min(rem,4) dwords on a data beat
   always_comb begin
      if (rem_dw >= 4) begin
         tail_mask = 16'hffff;
      end else begin
         case (rem_dw[1:0])
            2'd0:    tail_mask = 16'h0000;
            2'd1:    tail_mask = 16'h000f;
            2'd2:    tail_mask = 16'h00ff;
            default: tail_mask = 16'h0fff;
         endcase
      end
   end

   assign be_next = !s1_valid ? '0 : (s1_sop ? sop_mask : tail_mask); // idle beats carry no bytes

   // remaining count, gaps leave it alone
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         rem_dw <= '0;
      end else if (s1_valid) begin
         if (s1_sop)
            rem_dw <= rem_load;
         else if (rem_dw > 4)
            rem_dw <= rem_dw - 3'd4;
         else
            rem_dw <= '0; // saturate
      end
   end

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         s2_valid <= 1'b0;
         s2_sop   <= 1'b0;
         s2_eop   <= 1'b0;
         s2_be    <= '0;
      end else begin
         s2_valid <= s1_valid;
         s2_sop   <= s1_sop;
         s2_eop   <= s1_eop;
         s2_be    <= be_next;
      end
   end

   always_ff @(posedge clk_in) begin
      s2_data    <= s1_data;
      s2_err     <= s1_err;
      s2_empty   <= s1_empty;
      s2_hdr_3dw <= s1_hdr_3dw;
      s2_addr    <= s1_addr; // still held since sop
   end

endmodule

/* tlp_bar_decode.sv */
`timescale 1ns/1ps

module tlp_bar_decode (
   input  logic             clk_in,
   input  logic             rstn,
   input  tlp_pkg::data_t   s2_data,
   input  logic             s2_sop,
   input  logic             s2_eop,
   input  logic             s2_valid,
   input  logic             s2_err,
   input  logic             s2_empty,
   input  tlp_pkg::be_t     s2_be,
   input  tlp_pkg::addr_t   s2_addr,
   input  tlp_pkg::addr_t   bar2_base,
   input  tlp_pkg::addr_t   bar3_base,
   output tlp_pkg::data_t   tx_st_data_r,
   output logic             tx_st_sop_r,
   output logic             tx_st_eop_r,
   output logic             tx_st_valid_r,
   output logic             tx_st_err_r,
   output logic             tx_st_empty_r,
   output tlp_pkg::be_t     tx_st_be,
   output tlp_pkg::bardec_t tx_st_bardec
);

   tlp_pkg::bardec_t hit;

   // bar3 sits above bar2, check it first
   always_comb begin
      if (s2_addr >= bar3_base)
         hit = tlp_pkg::BAR3_HIT;
      else if (s2_addr >= bar2_base)
         hit = tlp_pkg::BAR2_HIT;
      else
         hit = '0; // below both, no bar
   end

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         tx_st_valid_r <= 1'b0;
         tx_st_sop_r   <= 1'b0;
         tx_st_eop_r   <= 1'b0;
         tx_st_be      <= '0;
         tx_st_bardec  <= '0;
      end else begin
         tx_st_valid_r <= s2_valid;
         tx_st_sop_r   <= s2_sop;
         tx_st_eop_r   <= s2_eop;
         tx_st_be      <= s2_be;
         if (s2_valid && s2_sop)
            tx_st_bardec <= hit; // held for the rest of the packet
      end
   end

   always_ff @(posedge clk_in) begin
      tx_st_data_r  <= s2_data;
      tx_st_err_r   <= s2_err;
      tx_st_empty_r <= s2_empty;
   end

endmodule

/* tlp_bar_regs.sv */
`timescale 1ns/1ps

module tlp_bar_regs (
   input  logic                clk_in,
   input  logic                rstn,
   input  tlp_pkg::axil_addr_t awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  tlp_pkg::axil_data_t wdata,
   input  logic [3:0]          wstrb,
   input  logic                wvalid,
   output logic                wready,
   output tlp_pkg::axil_resp_t bresp,
   output logic                bvalid,
   input  logic                bready,
   input  tlp_pkg::axil_addr_t araddr,
   input  logic                arvalid,
   output logic                arready,
   output tlp_pkg::axil_data_t rdata,
   output tlp_pkg::axil_resp_t rresp,
   output logic                rvalid,
   input  logic                rready,
   output tlp_pkg::addr_t      bar2_base,
   output tlp_pkg::addr_t      bar3_base
);

   tlp_pkg::reg_wr_state_t wr_state;
   logic                   wr_fire;
   logic                   rd_fire;

   // byte lanes of wdata over the old value
   function automatic tlp_pkg::addr_t merge_strb(input tlp_pkg::addr_t old_val,
                                                 input tlp_pkg::axil_data_t new_val,
                                                 input logic [3:0] strb);
      tlp_pkg::addr_t res;
      res = old_val;
      for (int i = 0; i < 4; i++) begin
         if (strb[i])
            res[8*i +: 8] = new_val[8*i +: 8];
      end
      return res;
   endfunction

   // aw and w taken in the same cycle only
   assign awready = (wr_state == tlp_pkg::write_idle) & wvalid;
   assign wready  = (wr_state == tlp_pkg::write_idle) & awvalid;
   assign wr_fire = awvalid & awready;
   assign bvalid  = (wr_state == tlp_pkg::write_resp);

   assign arready = ~rvalid; // one read outstanding
   assign rd_fire = arvalid & arready;

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         wr_state  <= tlp_pkg::write_idle;
         bar2_base <= tlp_pkg::BAR2_BASE_RST;
         bar3_base <= tlp_pkg::BAR3_BASE_RST;
      end else begin
         case (wr_state)
            tlp_pkg::write_idle: begin
               if (wr_fire) begin
                  if (awaddr == tlp_pkg::REG_BAR2_ADDR)
                     bar2_base <= merge_strb(bar2_base, wdata, wstrb);
                  if (awaddr == tlp_pkg::REG_BAR3_ADDR)
                     bar3_base <= merge_strb(bar3_base, wdata, wstrb);
                  wr_state <= tlp_pkg::write_resp;
               end
            end
            default: begin
               if (bready)
                  wr_state <= tlp_pkg::write_idle;
            end
         endcase
      end
   end

   // response captured with the write
   always_ff @(posedge clk_in) begin
      if (wr_fire)
         bresp <= (awaddr == tlp_pkg::REG_BAR2_ADDR || awaddr == tlp_pkg::REG_BAR3_ADDR) ?
                  tlp_pkg::RESP_OKAY : tlp_pkg::RESP_SLVERR;
   end

   always_ff @(posedge clk_in) begin
      if (!rstn)
         rvalid <= 1'b0;
      else if (rd_fire)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   // read data one cycle after ar
   always_ff @(posedge clk_in) begin
      if (rd_fire) begin
         case (araddr)
            tlp_pkg::REG_BAR2_ADDR: begin
               rdata <= bar2_base;
               rresp <= tlp_pkg::RESP_OKAY;
            end
            tlp_pkg::REG_BAR3_ADDR: begin
               rdata <= bar3_base;
               rresp <= tlp_pkg::RESP_OKAY;
            end
            default: begin
               rdata <= '0; // unmapped reads as zero
               rresp <= tlp_pkg::RESP_SLVERR;
            end
         endcase
      end
   end

endmodule

/* tlp_annotate_top.sv */
`timescale 1ns/1ps

module tlp_annotate_top (
   input  logic                clk_in,
   input  logic                rstn,
   input  tlp_pkg::data_t      tx_st_data,
   input  logic                tx_st_sop,
   input  logic                tx_st_eop,
   input  logic                tx_st_valid,
   input  logic                tx_st_err,
   input  logic                tx_st_empty,
   output tlp_pkg::data_t      tx_st_data_r,
   output logic                tx_st_sop_r,
   output logic                tx_st_eop_r,
   output logic                tx_st_valid_r,
   output logic                tx_st_err_r,
   output logic                tx_st_empty_r,
   output tlp_pkg::be_t        tx_st_be,
   output tlp_pkg::bardec_t    tx_st_bardec,
   input  tlp_pkg::axil_addr_t awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  tlp_pkg::axil_data_t wdata,
   input  logic [3:0]          wstrb,
   input  logic                wvalid,
   output logic                wready,
   output tlp_pkg::axil_resp_t bresp,
   output logic                bvalid,
   input  logic                bready,
   input  tlp_pkg::axil_addr_t araddr,
   input  logic                arvalid,
   output logic                arready,
   output tlp_pkg::axil_data_t rdata,
   output tlp_pkg::axil_resp_t rresp,
   output logic                rvalid,
   input  logic                rready
);

   // stage 1 out
   tlp_pkg::data_t     s1_data;
   logic               s1_sop, s1_eop, s1_valid, s1_err, s1_empty;
   logic               s1_hdr_3dw, s1_has_payload;
   tlp_pkg::dw_count_t s1_payload_dw;
   tlp_pkg::addr_t     s1_addr;
   // stage 2 out
   tlp_pkg::data_t     s2_data;
   logic               s2_sop, s2_eop, s2_valid, s2_err, s2_empty;
   tlp_pkg::be_t       s2_be;
   tlp_pkg::addr_t     s2_addr;
   // run-time bar bases
   tlp_pkg::addr_t     bar2_base, bar3_base;

   tlp_hdr_parse u_hdr_parse (
      .clk_in, .rstn,
      .tx_st_data, .tx_st_sop, .tx_st_eop, .tx_st_valid, .tx_st_err, .tx_st_empty,
      .s1_data, .s1_sop, .s1_eop, .s1_valid, .s1_err, .s1_empty,
      .s1_hdr_3dw, .s1_has_payload, .s1_payload_dw, .s1_addr
   );

   tlp_be_gen u_be_gen (
      .clk_in, .rstn,
      .s1_data, .s1_sop, .s1_eop, .s1_valid, .s1_err, .s1_empty,
      .s1_hdr_3dw, .s1_has_payload, .s1_payload_dw, .s1_addr,
      .s2_data, .s2_sop, .s2_eop, .s2_valid, .s2_err, .s2_empty,
      .s2_be, .s2_hdr_3dw(), .s2_addr // header size not needed past stage 2
   );

   tlp_bar_decode u_bar_decode (
      .clk_in, .rstn,
      .s2_data, .s2_sop, .s2_eop, .s2_valid, .s2_err, .s2_empty,
      .s2_be, .s2_addr, .bar2_base, .bar3_base,
      .tx_st_data_r, .tx_st_sop_r, .tx_st_eop_r, .tx_st_valid_r,
      .tx_st_err_r, .tx_st_empty_r, .tx_st_be, .tx_st_bardec
   );

   tlp_bar_regs u_bar_regs (
      .clk_in, .rstn,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .bar2_base, .bar3_base
   );

endmodule

/* tb_tlp_annotate.sv */
`timescale 1ns/1ps

module tb_tlp_annotate;

   localparam int WAIT_LIMIT  = 64;  // cycles per bus handshake
   localparam int DRAIN_LIMIT = 400; // cycles for the pipeline to empty

   // one expected output beat
   typedef struct packed {
      tlp_pkg::data_t   data;
      logic             sop;
      logic             eop;
      logic             err;
      logic             empty;
      tlp_pkg::be_t     be;
      tlp_pkg::bardec_t bardec;
      logic [31:0]      cyc; // cycle the beat was driven
   } beat_t;

   logic clk_in = 1'b0;
   logic rstn;
   tlp_pkg::data_t tx_st_data, tx_st_data_r;
   logic tx_st_sop, tx_st_eop, tx_st_valid, tx_st_err, tx_st_empty;
   logic tx_st_sop_r, tx_st_eop_r, tx_st_valid_r, tx_st_err_r, tx_st_empty_r;
   tlp_pkg::be_t tx_st_be;
   tlp_pkg::bardec_t tx_st_bardec;
   tlp_pkg::axil_addr_t awaddr, araddr;
   tlp_pkg::axil_data_t wdata, rdata;
   tlp_pkg::axil_resp_t bresp, rresp;
   logic [3:0] wstrb;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;

   logic [31:0]    lfsr_state = 32'h6203_b25d;
   logic [31:0]    cyc = '0;
   int             errors = 0;
   int             checks = 0;
   int             tests_run = 0;
   logic           aborted = 1'b0;
   tlp_pkg::addr_t model_bar2 = tlp_pkg::BAR2_BASE_RST; // register mirror
   tlp_pkg::addr_t model_bar3 = tlp_pkg::BAR3_BASE_RST;
   int             ref_rem = 0;                         // payload dwords left
   logic [7:0]     ref_bardec = '0;
   beat_t          exp_q[$];
   beat_t          mon_head;

   tlp_annotate_top UUT (
      .clk_in, .rstn,
      .tx_st_data, .tx_st_sop, .tx_st_eop, .tx_st_valid, .tx_st_err, .tx_st_empty,
      .tx_st_data_r, .tx_st_sop_r, .tx_st_eop_r, .tx_st_valid_r,
      .tx_st_err_r, .tx_st_empty_r, .tx_st_be, .tx_st_bardec,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
   );

   always #10 clk_in = ~clk_in; // 20 ns period

   always @(posedge clk_in) cyc <= cyc + 1; // read on the falling edge only

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state); // one step per bit
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function tlp_pkg::data_t random_data();
      return {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
   endfunction

   // expected be and bardec for one valid beat, straight from the header rules
   function logic [23:0] expected_beat(input tlp_pkg::data_t d, input logic sop);
      logic [15:0] be;
      logic [31:0] addr;
      int          len_dw;
      logic        four_dw;
      logic        pay;
      be      = '0;
      four_dw = d[tlp_pkg::FMT_4DW_BIT];
      pay     = d[tlp_pkg::FMT_PAYLOAD_BIT];
      if (sop) begin
         len_dw  = (d[9:0] == 0) ? 1024 : d[9:0]; // field 0 is 1024
         addr    = four_dw ? d[127:96] : d[95:64];
         be      = (!four_dw && !pay) ? 16'h0fff : 16'hffff;
         ref_rem = !pay ? 0 : (four_dw ? len_dw : len_dw - 1);
         if (addr >= model_bar3)
            ref_bardec = tlp_pkg::BAR3_HIT;
         else if (addr >= model_bar2)
            ref_bardec = tlp_pkg::BAR2_HIT;
         else
            ref_bardec = 8'h00;
      end else begin
         for (int i = 0; i < 4; i++)
            if (i < ref_rem)
               be[4*i +: 4] = 4'hf; // lowest dwords first
         ref_rem = (ref_rem > 4) ? ref_rem - 4 : 0;
      end
      return {ref_bardec, be};
   endfunction

   task automatic check_value(input string name, input logic [127:0] expv,
                              input logic [127:0] actv);
      checks++;
      if (actv !== expv) begin
         errors++;
         $display("ERR %0t %s expected %0h actual %0h", $time, name, expv, actv);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("%0t: timed out waiting for %s", $time, what);
      errors++;
      aborted = 1'b1;
   endtask

   // compare every valid output beat with the queue head
   always @(negedge clk_in) begin
      if (tx_st_valid_r === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("%0t: output beat with valid high but nothing was expected", $time);
            errors++;
         end else begin
            mon_head = exp_q.pop_front();
            check_value("tx_st_data_r", mon_head.data, tx_st_data_r);
            check_value("tx_st_sop_r", mon_head.sop, tx_st_sop_r);
            check_value("tx_st_eop_r", mon_head.eop, tx_st_eop_r);
            check_value("tx_st_err_r", mon_head.err, tx_st_err_r);
            check_value("tx_st_empty_r", mon_head.empty, tx_st_empty_r);
            check_value("tx_st_be", mon_head.be, tx_st_be);
            check_value("tx_st_bardec", mon_head.bardec, tx_st_bardec);
            check_value("latency", tlp_pkg::PIPE_LATENCY, cyc - mon_head.cyc);
         end
      end
   end

   task automatic drive_beat(input tlp_pkg::data_t d, input logic sop, input logic eop);
      beat_t       b;
      logic [23:0] ref_out;
      tx_st_data  = d;
      tx_st_sop   = sop;
      tx_st_eop   = eop;
      tx_st_valid = 1'b1;
      tx_st_err   = (rand_bits(3) == 0);       // rare error flag
      tx_st_empty = eop && (rand_bits(1) != 0); // only meaningful on eop
      ref_out     = expected_beat(d, sop);
      b = {d, sop, eop, tx_st_err, tx_st_empty, ref_out[15:0], ref_out[23:16], cyc};
      exp_q.push_back(b);
      @(negedge clk_in);
   endtask

   task automatic drive_idle();
      tx_st_valid = 1'b0;
      tx_st_sop   = (rand_bits(1) != 0); // junk while valid low
      tx_st_eop   = (rand_bits(1) != 0);
      tx_st_data  = random_data();
      @(negedge clk_in);
   endtask

   task automatic send_packet(input logic four_dw, input logic pay, input logic [9:0] len_f,
                              input tlp_pkg::addr_t addr, input logic gaps);
      tlp_pkg::data_t d;
      int             len_dw;
      int             rem;
      int             beats;
      len_dw = (len_f == 0) ? 1024 : len_f;
      rem    = !pay ? 0 : (four_dw ? len_dw : len_dw - 1);
      beats  = 1 + (rem + 3) / 4;
      d = random_data();
      d[31:0] = {1'b0, pay, four_dw, 19'd0, len_f}; // memory request, type 0
      if (four_dw)
         d[127:96] = addr; // low address dw
      else
         d[95:64] = addr;
      for (int b = 0; b < beats; b++) begin
         if (b > 0)
            d = random_data();
         for (int g = 0; g < 3 && gaps && rand_bits(2) == 0; g++)
            drive_idle();
         drive_beat(d, b == 0, b == beats - 1);
      end
      tx_st_valid = 1'b0;
      tx_st_sop   = 1'b0;
      tx_st_eop   = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
         @(negedge clk_in);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("%0t: %0d expected beats never left the pipeline", $time, exp_q.size());
         errors++;
         aborted = 1'b1;
         exp_q.delete();
      end
   endtask

   task automatic axil_write(input tlp_pkg::axil_addr_t a, input tlp_pkg::axil_data_t d,
                             input logic [3:0] strb, output tlp_pkg::axil_resp_t resp);
      logic [31:0] mask;
      int          n;
      awaddr  = a;
      wdata   = d;
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      n = 0;
      @(posedge clk_in); // readies seen here are the ones this edge acts on
      while (!(awready && wready) && n < WAIT_LIMIT) begin
         @(posedge clk_in);
         n++;
      end
      if (!(awready && wready))
         report_timeout("awready and wready");
      @(negedge clk_in); // aw and w taken on the edge just passed
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      n = 0;
      while (!bvalid && n < WAIT_LIMIT) begin
         @(negedge clk_in);
         n++;
      end
      if (!bvalid)
         report_timeout("bvalid");
      resp = bresp;
      @(negedge clk_in);
      bready = 1'b0;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      if (a == tlp_pkg::REG_BAR2_ADDR)
         model_bar2 = (model_bar2 & ~mask) | (d & mask);
      if (a == tlp_pkg::REG_BAR3_ADDR)
         model_bar3 = (model_bar3 & ~mask) | (d & mask);
   endtask

   task automatic axil_read(input tlp_pkg::axil_addr_t a, output tlp_pkg::axil_data_t d,
                            output tlp_pkg::axil_resp_t resp);
      int n;
      araddr  = a;
      arvalid = 1'b1;
      rready  = 1'b1;
      n = 0;
      while (!arready && n < WAIT_LIMIT) begin
         @(negedge clk_in);
         n++;
      end
      if (!arready)
         report_timeout("arready");
      @(negedge clk_in); // ar taken
      arvalid = 1'b0;
      n = 0;
      while (!rvalid && n < WAIT_LIMIT) begin
         @(negedge clk_in);
         n++;
      end
      if (!rvalid)
         report_timeout("rvalid");
      d    = rdata;
      resp = rresp;
      @(negedge clk_in);
      rready = 1'b0;
   endtask

   task automatic write_expect(input tlp_pkg::axil_addr_t a, input tlp_pkg::axil_data_t d,
                               input logic [3:0] strb, input tlp_pkg::axil_resp_t exp_r);
      tlp_pkg::axil_resp_t r;
      axil_write(a, d, strb, r);
      check_value("bresp", exp_r, r);
   endtask

   task automatic read_expect(input tlp_pkg::axil_addr_t a, input tlp_pkg::axil_data_t exp_d,
                              input tlp_pkg::axil_resp_t exp_r);
      tlp_pkg::axil_data_t d;
      tlp_pkg::axil_resp_t r;
      axil_read(a, d, r);
      check_value("rdata", exp_d, d);
      check_value("rresp", exp_r, r);
   endtask

   task automatic close_test(input string name, input int err0);
      tests_run++;
      $display("test %s done, %0d errors", name, errors - err0);
   endtask

   task automatic after_reset();
      int e0;
      e0 = errors;
      check_value("tx_st_valid_r", 0, tx_st_valid_r);
      check_value("tx_st_be", 0, tx_st_be);
      check_value("tx_st_bardec", 0, tx_st_bardec);
      check_value("arready", 1, arready);
      read_expect(tlp_pkg::REG_BAR2_ADDR, tlp_pkg::BAR2_BASE_RST, tlp_pkg::RESP_OKAY);
      read_expect(tlp_pkg::REG_BAR3_ADDR, tlp_pkg::BAR3_BASE_RST, tlp_pkg::RESP_OKAY);
      close_test("reset", e0);
   endtask

   task automatic exercise_registers();
      int e0;
      e0 = errors;
      write_expect(tlp_pkg::REG_BAR2_ADDR, 32'h0030_0000, 4'hf, tlp_pkg::RESP_OKAY);
      read_expect(tlp_pkg::REG_BAR2_ADDR, 32'h0030_0000, tlp_pkg::RESP_OKAY);
      // bytes 0 and 2 only, over 0024_0000
      write_expect(tlp_pkg::REG_BAR3_ADDR, 32'haabb_ccdd, 4'b0101, tlp_pkg::RESP_OKAY);
      read_expect(tlp_pkg::REG_BAR3_ADDR, 32'h00bb_00dd, tlp_pkg::RESP_OKAY);
      write_expect(4'h8, 32'hdead_beef, 4'hf, tlp_pkg::RESP_SLVERR); // unmapped
      read_expect(4'h8, 32'h0, tlp_pkg::RESP_SLVERR);
      read_expect(tlp_pkg::REG_BAR2_ADDR, 32'h0030_0000, tlp_pkg::RESP_OKAY);
      read_expect(tlp_pkg::REG_BAR3_ADDR, 32'h00bb_00dd, tlp_pkg::RESP_OKAY);
      write_expect(tlp_pkg::REG_BAR2_ADDR, tlp_pkg::BAR2_BASE_RST, 4'hf, tlp_pkg::RESP_OKAY);
      write_expect(tlp_pkg::REG_BAR3_ADDR, tlp_pkg::BAR3_BASE_RST, 4'hf, tlp_pkg::RESP_OKAY);
      close_test("registers", e0);
   endtask

   task automatic sweep_byte_enables();
      int e0;
      e0 = errors;
      for (int h = 0; h < 2; h++)
         for (int p = 0; p < 2; p++)
            for (int len = 0; len < 10; len++) // field 0 is the 1024 case
               send_packet(h[0], p[0], 10'(len), rand_bits(32), 1'b0);
      repeat (12)
         send_packet(rand_bits(1) != 0, rand_bits(1) != 0, 10'(rand_bits(10)),
                     rand_bits(32), 1'b1);
      wait_drain();
      close_test("byte enables", e0);
   endtask

   // addresses around the current bases
   task automatic bar_sweep();
      send_packet(1'b0, 1'b1, 10'd9, model_bar2 - 32'd4, 1'b1);
      send_packet(1'b1, 1'b1, 10'd9, model_bar2, 1'b1);
      send_packet(1'b0, 1'b1, 10'd9, model_bar2 + (model_bar3 - model_bar2) / 2, 1'b1);
      send_packet(1'b1, 1'b1, 10'd9, model_bar3 - 32'd4, 1'b1);
      send_packet(1'b0, 1'b1, 10'd9, model_bar3, 1'b1);
      send_packet(1'b1, 1'b0, 10'd1, 32'hffff_fffc, 1'b1);
      send_packet(1'b0, 1'b1, 10'd5, 32'h0000_0000, 1'b1);
      repeat (6)
         send_packet(rand_bits(1) != 0, 1'b1, 10'd6,
                     model_bar2 - 32'h800 + rand_bits(13), 1'b1);
      wait_drain();
   endtask

   task automatic decode_bars();
      int e0;
      e0 = errors;
      bar_sweep(); // reset bases
      write_expect(tlp_pkg::REG_BAR2_ADDR, 32'h4000_0000, 4'hf, tlp_pkg::RESP_OKAY);
      write_expect(tlp_pkg::REG_BAR3_ADDR, 32'h4000_1000, 4'hf, tlp_pkg::RESP_OKAY);
      bar_sweep();
      close_test("bar decode", e0);
   endtask

   task automatic stream_with_gaps();
      int e0;
      e0 = errors;
      repeat (10)
         send_packet(rand_bits(1) != 0, 1'b1, 10'(rand_bits(5)), rand_bits(32), 1'b1);
      send_packet(1'b0, 1'b0, 10'd4, rand_bits(32), 1'b1);
      send_packet(1'b1, 1'b0, 10'd2, rand_bits(32), 1'b1);
      wait_drain();
      close_test("pass-through", e0);
   endtask

   initial begin
      rstn        = 1'b0;
      tx_st_data  = {4{32'h4000_0003}}; // header beat held through reset
      tx_st_sop   = 1'b1;
      tx_st_eop   = 1'b1;
      tx_st_valid = 1'b1;
      tx_st_err   = 1'b0;
      tx_st_empty = 1'b0;
      awaddr      = '0;
      awvalid     = 1'b0;
      wdata       = '0;
      wstrb       = '0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = '0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      repeat (16) @(negedge clk_in); // 16 cycles in reset
      rstn        = 1'b1;
      tx_st_data  = '0;
      tx_st_sop   = 1'b0;
      tx_st_eop   = 1'b0;
      tx_st_valid = 1'b0;
      @(negedge clk_in);
      after_reset();
      if (!aborted)
         exercise_registers();
      if (!aborted)
         sweep_byte_enables();
      if (!aborted)
         decode_bars();
      if (!aborted)
         stream_with_gaps();
      wait_drain();
      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* sim.f */
tlp_pkg.sv
tlp_hdr_parse.sv
tlp_be_gen.sv
tlp_bar_decode.sv
tlp_bar_regs.sv
tlp_annotate_top.sv
tb_tlp_annotate.sv

/* Bender.yml */
package:
  name: tlp_annotate

sources:
  - tlp_pkg.sv
  - tlp_hdr_parse.sv
  - tlp_be_gen.sv
  - tlp_bar_decode.sv
  - tlp_bar_regs.sv
  - tlp_annotate_top.sv
  - target: simulation
    files:
      - tb_tlp_annotate.sv
